// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= edpTb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== files.f ====
+incdir+hdl
hdl/cramPkg.sv
hdl/ebusPkg.sv
hdl/cramDecode.sv
hdl/edpExecute.sv
hdl/fastMem.sv
hdl/ebusResult.sv
hdl/edpTop.sv
tb/edpTb.sv

// ==== hdl/cramDecode.sv ====
`timescale 1ns/1ps

module cramDecode (
  input  cramPkg::adFuncE    adFunc,
  input  cramPkg::adaSelE    adaSel,
  input  cramPkg::adbSelE    adbSel,
  input  cramPkg::arSelE     arSel,
  input  cramPkg::arxSelE    arxSel,
  input  cramPkg::mqSelE     mqSel,
  input  cramPkg::fmWriteE   fmWrite,
  input  logic               brLoad,
  input  logic               brxLoad,
  input  ebusPkg::diagFuncE  diagFunc,
  input  logic               adToEbus,
  output logic               arLeftLoad,
  output logic               arRightLoad,
  output logic               arLeftClr,
  output logic               arRightClr,
  output cramPkg::arSelE     arLeftSrc,
  output cramPkg::arSelE     arRightSrc,
  output logic               fmWeLeft,
  output logic               fmWeRight,
  output ebusPkg::diagFuncE  ebusSrc,
  output logic               ebusEnable,
  output cramPkg::adFuncE    exAdFunc,
  output cramPkg::adaSelE    exAdaSel,
  output cramPkg::adbSelE    exAdbSel,
  output cramPkg::arxSelE    exArxSel,
  output cramPkg::mqSelE     exMqSel,
  output logic               exBrLoad,
  output logic               exBrxLoad
);

  // AR field split into per-half strobes
  always_comb begin
    arLeftLoad  = 1'b0;
    arRightLoad = 1'b0;
    arLeftClr   = 1'b0;
    arRightClr  = 1'b0;
    arLeftSrc   = cramPkg::arHold;
    arRightSrc  = cramPkg::arHold;
    case (arSel)
      cramPkg::arAd, cramPkg::arCache, cramPkg::arEbus, cramPkg::arArx: begin
        arLeftLoad  = 1'b1;
        arRightLoad = 1'b1;
        arLeftSrc   = arSel;
        arRightSrc  = arSel;
      end
      cramPkg::arClrLeft:  arLeftClr = 1'b1;
      cramPkg::arClrRight: arRightClr = 1'b1;
      cramPkg::arClrAll: begin
        arLeftClr  = 1'b1;
        arRightClr = 1'b1;
      end
      default: ;
    endcase
  end

  assign fmWeLeft  = (fmWrite == cramPkg::fmLeft) || (fmWrite == cramPkg::fmBoth);
  assign fmWeRight = (fmWrite == cramPkg::fmRight) || (fmWrite == cramPkg::fmBoth);

  // AD transfer overrides any diagnostic read
  assign ebusSrc    = adToEbus ? ebusPkg::diagAd : diagFunc;
  assign ebusEnable = adToEbus || (diagFunc != ebusPkg::diagIdle);

  assign exAdFunc  = adFunc;
  assign exAdaSel  = adaSel;
  assign exAdbSel  = adbSel;
  assign exArxSel  = arxSel;
  assign exMqSel   = mqSel;
  assign exBrLoad  = brLoad;
  assign exBrxLoad = brxLoad;

endmodule

// ==== hdl/cramPkg.sv ====
package cramPkg;

  // AD function, arithmetic first
  typedef enum logic [2:0] {
    adAdd,
    adSub,
    adAnd,
    adOr,
    adXor,
    adPassA,
    adPassB,
    adZero
  } adFuncE;

  typedef enum logic [1:0] {adaAr, adaArx, adaMq, adaZero} adaSelE;

  // adbMagic brings in the magic field zero extended
  typedef enum logic [1:0] {adbFm, adbBr, adbBrx, adbMagic} adbSelE;

  typedef enum logic [2:0] {
    arHold,
    arAd,
    arCache,
    arEbus,
    arClrLeft,
    arClrRight,
    arClrAll,
    arArx
  } arSelE;

  typedef enum logic [1:0] {arxHold, arxAd, arxCache, arxMq} arxSelE;

  // Shift left takes AD carry in at the low end, shift right keeps the sign
  typedef enum logic [1:0] {mqHold, mqLoadAd, mqShl, mqShr} mqSelE;

  typedef enum logic [1:0] {fmNone, fmLeft, fmRight, fmBoth} fmWriteE;

endpackage

// ==== hdl/ebusPkg.sv ====
package ebusPkg;

  // Diagnostic read source on the EBUS
  typedef enum logic [2:0] {
    diagAr,
    diagBr,
    diagMq,
    diagFm,
    diagBrx,
    diagArx,
    diagAd,
    diagIdle
  } diagFuncE;

endpackage

// ==== hdl/ebusResult.sv ====
`timescale 1ns/1ps
`include "edp_params.svh"

module ebusResult (
  input  logic                           eboxClk,
  input  logic                           rstN,
  input  ebusPkg::diagFuncE              ebusSrc,
  input  logic                           ebusEnable,
  input  logic [0:`EDP_WIDTH-1]          ar,
  input  logic [0:`EDP_WIDTH-1]          br,
  input  logic [0:`EDP_WIDTH-1]          mq,
  input  logic [0:`EDP_WIDTH-1]          fm,
  input  logic [0:`EDP_WIDTH-1]          brx,
  input  logic [0:`EDP_WIDTH-1]          arx,
  input  logic [-`EDP_EXT:`EDP_WIDTH-1]  ad,
  output logic [0:`EDP_WIDTH-1]          ebusData,
  output logic                           ebusDrive
);

  logic [0:`EDP_WIDTH-1] selWord;

  always_comb begin
    case (ebusSrc)
      ebusPkg::diagAr:  selWord = ar;
      ebusPkg::diagBr:  selWord = br;
      ebusPkg::diagMq:  selWord = mq;
      ebusPkg::diagFm:  selWord = fm;
      ebusPkg::diagBrx: selWord = brx;
      ebusPkg::diagArx: selWord = arx;
      ebusPkg::diagAd:  selWord = ad[0:`EDP_WIDTH-1];
      default:          selWord = '0;
    endcase
  end

  // Bus is held at zero whenever the EDP is not driving
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ebusDrive <= 1'b0;
      ebusData  <= '0;
    end else begin
      ebusDrive <= ebusEnable;
      if (ebusEnable) begin
        ebusData <= selWord;
      end else begin
        ebusData <= '0;
      end
    end
  end

endmodule

// ==== hdl/edpExecute.sv ====
`timescale 1ns/1ps
`include "edp_params.svh"

module edpExecute (
  input  logic                                eboxClk,
  input  logic                                rstN,
  input  logic                                arLeftLoad,
  input  logic                                arRightLoad,
  input  logic                                arLeftClr,
  input  logic                                arRightClr,
  input  cramPkg::arSelE                      arLeftSrc,
  input  cramPkg::arSelE                      arRightSrc,
  input  cramPkg::arxSelE                     arxSel,
  input  cramPkg::mqSelE                      mqSel,
  input  logic                                brLoad,
  input  logic                                brxLoad,
  input  cramPkg::adaSelE                     adaSel,
  input  cramPkg::adbSelE                     adbSel,
  input  cramPkg::adFuncE                     adFunc,
  input  logic [0:`MAGIC_W-1]                 magic,
  input  logic [0:`EDP_WIDTH-1]               fm,
  input  logic [0:`EDP_WIDTH-1]               cacheData,
  input  logic [0:`EDP_WIDTH-1]               ebusIn,
  input  logic                                carryIn,
  output logic [-`EDP_EXT:`EDP_WIDTH-1]       ad,
  output logic                                adCarry,
  output logic [0:`EDP_WIDTH-1]               ar,
  output logic [0:`EDP_WIDTH-1]               arx,
  output logic [0:`EDP_WIDTH-1]               br,
  output logic [0:`EDP_WIDTH-1]               brx,
  output logic [0:`EDP_WIDTH-1]               mq
);

  localparam int halfW = `EDP_WIDTH / 2;

  logic [0:`EDP_WIDTH-1] adaVal, adbVal, adbOp;
  logic [0:`EDP_WIDTH-1] sumLow, logicRes;
  logic [0:`EDP_EXT-1]   sumExt;
  logic                  sumCarry, addCin;
  logic [0:`EDP_WIDTH-1] arLeftWord, arRightWord;

  function automatic logic [0:`EDP_WIDTH-1] arSource(
    input cramPkg::arSelE        src,
    input logic [0:`EDP_WIDTH-1] adWord,
    input logic [0:`EDP_WIDTH-1] cacheWord,
    input logic [0:`EDP_WIDTH-1] ebusWord,
    input logic [0:`EDP_WIDTH-1] arxWord,
    input logic [0:`EDP_WIDTH-1] holdWord
  );
    case (src)
      cramPkg::arAd:    return adWord;
      cramPkg::arCache: return cacheWord;
      cramPkg::arEbus:  return ebusWord;
      cramPkg::arArx:   return arxWord;
      default:          return holdWord;
    endcase
  endfunction

  always_comb begin
    case (adaSel)
      cramPkg::adaAr:  adaVal = ar;
      cramPkg::adaArx: adaVal = arx;
      cramPkg::adaMq:  adaVal = mq;
      default:         adaVal = '0;
    endcase
    case (adbSel)
      cramPkg::adbFm:  adbVal = fm;
      cramPkg::adbBr:  adbVal = br;
      cramPkg::adbBrx: adbVal = brx;
      default:         adbVal = {{(`EDP_WIDTH-`MAGIC_W){1'b0}}, magic};
    endcase
  end

  // Subtract is A plus ~B plus one, carryIn only matters for add
  always_comb begin
    adbOp  = (adFunc == cramPkg::adSub) ? ~adbVal : adbVal;
    addCin = (adFunc == cramPkg::adSub) ? 1'b1 : carryIn;
    {sumCarry, sumLow} = {1'b0, adaVal} + {1'b0, adbOp} + {{`EDP_WIDTH{1'b0}}, addCin};
    // Extension bits see both operands sign extended
    sumExt = {`EDP_EXT{adaVal[0]}} + {`EDP_EXT{adbOp[0]}}
             + {{(`EDP_EXT-1){1'b0}}, sumCarry};
    case (adFunc)
      cramPkg::adAnd:   logicRes = adaVal & adbVal;
      cramPkg::adOr:    logicRes = adaVal | adbVal;
      cramPkg::adXor:   logicRes = adaVal ^ adbVal;
      cramPkg::adPassA: logicRes = adaVal;
      cramPkg::adPassB: logicRes = adbVal;
      default:          logicRes = '0;
    endcase
    if (adFunc == cramPkg::adAdd || adFunc == cramPkg::adSub) begin
      ad      = {sumExt, sumLow};
      adCarry = sumCarry;
    end else begin
      ad      = {{`EDP_EXT{logicRes[0]}}, logicRes};
      adCarry = 1'b0;
    end
  end

  always_comb begin
    arLeftWord  = arSource(arLeftSrc, ad[0:`EDP_WIDTH-1], cacheData, ebusIn, arx, ar);
    arRightWord = arSource(arRightSrc, ad[0:`EDP_WIDTH-1], cacheData, ebusIn, arx, ar);
  end

  // AR halves, clear beats load
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ar <= '0;
    end else begin
      if (arLeftClr) begin
        ar[0:halfW-1] <= '0;
      end else if (arLeftLoad) begin
        ar[0:halfW-1] <= arLeftWord[0:halfW-1];
      end
      if (arRightClr) begin
        ar[halfW:`EDP_WIDTH-1] <= '0;
      end else if (arRightLoad) begin
        ar[halfW:`EDP_WIDTH-1] <= arRightWord[halfW:`EDP_WIDTH-1];
      end
    end
  end

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      arx <= '0;
    end else begin
      case (arxSel)
        cramPkg::arxAd:    arx <= ad[0:`EDP_WIDTH-1];
        cramPkg::arxCache: arx <= cacheData;
        cramPkg::arxMq:    arx <= mq;
        default:           arx <= arx;
      endcase
    end
  end

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      br  <= '0;
      brx <= '0;
    end else begin
      if (brLoad) begin
        br <= ar;
      end
      if (brxLoad) begin
        brx <= arx;
      end
    end
  end

  // MQ as a shift register
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      mq <= '0;
    end else begin
      case (mqSel)
        cramPkg::mqLoadAd: mq <= ad[0:`EDP_WIDTH-1];
        cramPkg::mqShl:    mq <= {mq[1:`EDP_WIDTH-1], adCarry};
        cramPkg::mqShr:    mq <= {mq[0], mq[0:`EDP_WIDTH-2]};
        default:           mq <= mq;
      endcase
    end
  end

endmodule

// ==== hdl/edpTop.sv ====
`timescale 1ns/1ps
`include "edp_params.svh"

module edpTop (
  input  logic                           eboxClk,
  input  logic                           rstN,
  input  cramPkg::adFuncE                adFunc,
  input  cramPkg::adaSelE                adaSel,
  input  cramPkg::adbSelE                adbSel,
  input  cramPkg::arSelE                 arSel,
  input  cramPkg::arxSelE                arxSel,
  input  cramPkg::mqSelE                 mqSel,
  input  cramPkg::fmWriteE               fmWrite,
  input  logic                           brLoad,
  input  logic                           brxLoad,
  input  logic [0:`MAGIC_W-1]            magic,
  input  logic [`FM_ADDR_W-1:0]          fmAddr,
  input  logic                           carryIn,
  input  ebusPkg::diagFuncE              diagFunc,
  input  logic                           adToEbus,
  input  logic [0:`EDP_WIDTH-1]          cacheData,
  input  logic [0:`EDP_WIDTH-1]          ebusIn,
  output logic [-`EDP_EXT:`EDP_WIDTH-1]  ad,
  output logic                           adCarry,
  output logic [0:`EDP_WIDTH-1]          ar,
  output logic [0:`EDP_WIDTH-1]          arx,
  output logic [0:`EDP_WIDTH-1]          br,
  output logic [0:`EDP_WIDTH-1]          mq,
  output logic [0:`EDP_WIDTH-1]          fm,
  output logic                           fmParity,
  output logic [0:`EDP_WIDTH-1]          ebusData,
  output logic                           ebusDrive
);

  logic                  arLeftLoad, arRightLoad, arLeftClr, arRightClr;
  cramPkg::arSelE        arLeftSrc, arRightSrc;
  logic                  fmWeLeft, fmWeRight;
  ebusPkg::diagFuncE     ebusSrc;
  logic                  ebusEnable;
  cramPkg::adFuncE       exAdFunc;
  cramPkg::adaSelE       exAdaSel;
  cramPkg::adbSelE       exAdbSel;
  cramPkg::arxSelE       exArxSel;
  cramPkg::mqSelE        exMqSel;
  logic                  exBrLoad, exBrxLoad;
  logic [0:`EDP_WIDTH-1] brx;

  cramDecode uDecode (
    .adFunc(adFunc), .adaSel(adaSel), .adbSel(adbSel), .arSel(arSel),
    .arxSel(arxSel), .mqSel(mqSel), .fmWrite(fmWrite), .brLoad(brLoad),
    .brxLoad(brxLoad), .diagFunc(diagFunc), .adToEbus(adToEbus),
    .arLeftLoad(arLeftLoad), .arRightLoad(arRightLoad),
    .arLeftClr(arLeftClr), .arRightClr(arRightClr),
    .arLeftSrc(arLeftSrc), .arRightSrc(arRightSrc),
    .fmWeLeft(fmWeLeft), .fmWeRight(fmWeRight),
    .ebusSrc(ebusSrc), .ebusEnable(ebusEnable),
    .exAdFunc(exAdFunc), .exAdaSel(exAdaSel), .exAdbSel(exAdbSel),
    .exArxSel(exArxSel), .exMqSel(exMqSel),
    .exBrLoad(exBrLoad), .exBrxLoad(exBrxLoad)
  );

  edpExecute uExecute (
    .eboxClk(eboxClk), .rstN(rstN),
    .arLeftLoad(arLeftLoad), .arRightLoad(arRightLoad),
    .arLeftClr(arLeftClr), .arRightClr(arRightClr),
    .arLeftSrc(arLeftSrc), .arRightSrc(arRightSrc),
    .arxSel(exArxSel), .mqSel(exMqSel), .brLoad(exBrLoad), .brxLoad(exBrxLoad),
    .adaSel(exAdaSel), .adbSel(exAdbSel), .adFunc(exAdFunc),
    .magic(magic), .fm(fm), .cacheData(cacheData), .ebusIn(ebusIn),
    .carryIn(carryIn), .ad(ad), .adCarry(adCarry),
    .ar(ar), .arx(arx), .br(br), .brx(brx), .mq(mq)
  );

  // FM is always written from AR
  fastMem uFastMem (
    .eboxClk(eboxClk), .rstN(rstN), .fmAddr(fmAddr), .writeData(ar),
    .fmWeLeft(fmWeLeft), .fmWeRight(fmWeRight), .fm(fm), .fmParity(fmParity)
  );

  ebusResult uEbusResult (
    .eboxClk(eboxClk), .rstN(rstN), .ebusSrc(ebusSrc), .ebusEnable(ebusEnable),
    .ar(ar), .br(br), .mq(mq), .fm(fm), .brx(brx), .arx(arx), .ad(ad),
    .ebusData(ebusData), .ebusDrive(ebusDrive)
  );

endmodule

// ==== hdl/edp_params.svh ====
`ifndef EDP_PARAMS_SVH
`define EDP_PARAMS_SVH

// Data word width, bit 0 is the sign
`define EDP_WIDTH 36

// Sign extension bits carried above bit 0 of AD
`define EDP_EXT 2

// Fast memory geometry
`define FM_DEPTH 16
`define FM_ADDR_W 4

// Microword magic number field
`define MAGIC_W 9

`endif

// ==== hdl/fastMem.sv ====
`timescale 1ns/1ps
`include "edp_params.svh"

module fastMem (
  input  logic                   eboxClk,
  input  logic                   rstN,
  input  logic [`FM_ADDR_W-1:0]  fmAddr,
  input  logic [0:`EDP_WIDTH-1]  writeData,
  input  logic                   fmWeLeft,
  input  logic                   fmWeRight,
  output logic [0:`EDP_WIDTH-1]  fm,
  output logic                   fmParity
);

  localparam int halfW = `EDP_WIDTH / 2;

  logic [0:`EDP_WIDTH-1] mem [0:`FM_DEPTH-1];

  // Each half has its own write enable
  always_ff @(posedge eboxClk) begin
    if (fmWeLeft) begin
      mem[fmAddr][0:halfW-1] <= writeData[0:halfW-1];
    end
    if (fmWeRight) begin
      mem[fmAddr][halfW:`EDP_WIDTH-1] <= writeData[halfW:`EDP_WIDTH-1];
    end
  end

  // Registered read, returns the old word on a same-cycle write
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      fm <= '0;
    end else begin
      fm <= mem[fmAddr];
    end
  end

  assign fmParity = ^fm;

endmodule

// ==== tb/edpTb.sv ====
`timescale 1ns/1ps
`include "edp_params.svh"

module edpTb;

  localparam int halfW = `EDP_WIDTH / 2;

  logic                          eboxClk;
  logic                          rstN;
  cramPkg::adFuncE               adFunc;
  cramPkg::adaSelE               adaSel;
  cramPkg::adbSelE               adbSel;
  cramPkg::arSelE                arSel;
  cramPkg::arxSelE               arxSel;
  cramPkg::mqSelE                mqSel;
  cramPkg::fmWriteE              fmWrite;
  ebusPkg::diagFuncE             diagFunc;
  logic                          brLoad, brxLoad, carryIn, adToEbus;
  logic [0:`MAGIC_W-1]           magic;
  logic [`FM_ADDR_W-1:0]         fmAddr;
  logic [0:`EDP_WIDTH-1]         cacheData, ebusIn;
  logic [-`EDP_EXT:`EDP_WIDTH-1] ad;
  logic                          adCarry, fmParity, ebusDrive;
  logic [0:`EDP_WIDTH-1]         ar, arx, br, mq, fm, ebusData;

  // Reference model of the data path
  logic [0:`EDP_WIDTH-1] mAr, mArx, mBr, mBrx, mMq, mFmOut, mEbusData;
  logic [0:`EDP_WIDTH-1] mFm [0:`FM_DEPTH-1];
  logic                  mFmKnown [0:`FM_DEPTH-1];
  logic                  mFmOutKnown, mEbusDrive;
  integer                seed;
  logic [31:0]           rnd;

  edpTop i_dut (.*);

  initial eboxClk = 1'b0;
  always #2 eboxClk = ~eboxClk;

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "testbench stopped on the first failed check");
  endtask

  initial begin
    #20000;
    reportFail("timeout: the run went past its time limit");
  end

  assert property (@(posedge eboxClk) disable iff (!rstN) !ebusDrive |-> ebusData == '0)
    else reportFail($sformatf("mismatch ebusData exp %h got %h", 36'h0, $sampled(ebusData)));

  task automatic checkWord(input string name, input logic [0:`EDP_WIDTH-1] exp,
                           input logic [0:`EDP_WIDTH-1] got);
    assert (got === exp)
      else reportFail($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  task automatic checkBit(input string name, input logic exp, input logic got);
    assert (got === exp)
      else reportFail($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  function automatic logic [0:`EDP_WIDTH-1] randWord();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[`EDP_WIDTH-1:0];
  endfunction

  // Expected {carry, AD} from the model registers and the current microword
  function automatic logic [`EDP_WIDTH+`EDP_EXT:0] expectedAd();
    logic [0:`EDP_WIDTH-1]          a, b, bOp, lres;
    logic [`EDP_WIDTH:0]            low;
    logic [`EDP_WIDTH+`EDP_EXT-1:0] full;
    logic                           c;
    case (adaSel)
      cramPkg::adaAr:  a = mAr;
      cramPkg::adaArx: a = mArx;
      cramPkg::adaMq:  a = mMq;
      default:         a = '0;
    endcase
    case (adbSel)
      cramPkg::adbFm:  b = mFmOut;
      cramPkg::adbBr:  b = mBr;
      cramPkg::adbBrx: b = mBrx;
      default:         b = {{(`EDP_WIDTH-`MAGIC_W){1'b0}}, magic};
    endcase
    bOp = (adFunc == cramPkg::adSub) ? ~b : b;
    c = (adFunc == cramPkg::adSub) ? 1'b1 : carryIn;
    case (adFunc)
      cramPkg::adAnd:   lres = a & b;
      cramPkg::adOr:    lres = a | b;
      cramPkg::adXor:   lres = a ^ b;
      cramPkg::adPassA: lres = a;
      cramPkg::adPassB: lres = b;
      default:          lres = '0;
    endcase
    if (adFunc == cramPkg::adAdd || adFunc == cramPkg::adSub) begin
      low = {1'b0, a} + {1'b0, bOp} + {{`EDP_WIDTH{1'b0}}, c};
      full = {{`EDP_EXT{a[0]}}, a} + {{`EDP_EXT{bOp[0]}}, bOp}
             + {{(`EDP_WIDTH+`EDP_EXT-1){1'b0}}, c};
      return {low[`EDP_WIDTH], full};
    end
    return {1'b0, {`EDP_EXT{lres[0]}}, lres};
  endfunction

  task automatic checkOutputs();
    logic [`EDP_WIDTH+`EDP_EXT:0] e;
    e = expectedAd();
    // AD is only predictable once the FM word feeding it is known
    if (adbSel != cramPkg::adbFm || mFmOutKnown) begin
      assert (ad === e[`EDP_WIDTH+`EDP_EXT-1:0])
        else reportFail($sformatf("mismatch ad exp %h got %h",
                                  e[`EDP_WIDTH+`EDP_EXT-1:0], ad));
      checkBit("adCarry", e[`EDP_WIDTH+`EDP_EXT], adCarry);
    end
    checkWord("ar", mAr, ar);
    checkWord("arx", mArx, arx);
    checkWord("br", mBr, br);
    checkWord("mq", mMq, mq);
    checkWord("ebusData", mEbusData, ebusData);
    checkBit("ebusDrive", mEbusDrive, ebusDrive);
    if (mFmOutKnown) begin
      checkWord("fm", mFmOut, fm);
      checkBit("fmParity", ^mFmOut, fmParity);
    end
  endtask

  task automatic advanceModel();
    logic [`EDP_WIDTH+`EDP_EXT:0] e;
    logic [0:`EDP_WIDTH-1]        adWord, nAr, nArx, nMq, selWord;
    ebusPkg::diagFuncE            src;
    logic                         en;
    e = expectedAd();
    adWord = e[`EDP_WIDTH-1:0];
    case (arSel)
      cramPkg::arAd:       nAr = adWord;
      cramPkg::arCache:    nAr = cacheData;
      cramPkg::arEbus:     nAr = ebusIn;
      cramPkg::arArx:      nAr = mArx;
      cramPkg::arClrLeft:  nAr = {{halfW{1'b0}}, mAr[halfW:`EDP_WIDTH-1]};
      cramPkg::arClrRight: nAr = {mAr[0:halfW-1], {halfW{1'b0}}};
      cramPkg::arClrAll:   nAr = '0;
      default:             nAr = mAr;
    endcase
    case (arxSel)
      cramPkg::arxAd:    nArx = adWord;
      cramPkg::arxCache: nArx = cacheData;
      cramPkg::arxMq:    nArx = mMq;
      default:           nArx = mArx;
    endcase
    case (mqSel)
      cramPkg::mqLoadAd: nMq = adWord;
      cramPkg::mqShl:    nMq = {mMq[1:`EDP_WIDTH-1], e[`EDP_WIDTH+`EDP_EXT]};
      cramPkg::mqShr:    nMq = {mMq[0], mMq[0:`EDP_WIDTH-2]};
      default:           nMq = mMq;
    endcase
    src = adToEbus ? ebusPkg::diagAd : diagFunc;
    en = adToEbus || (diagFunc != ebusPkg::diagIdle);
    case (src)
      ebusPkg::diagAr:  selWord = mAr;
      ebusPkg::diagBr:  selWord = mBr;
      ebusPkg::diagMq:  selWord = mMq;
      ebusPkg::diagFm:  selWord = mFmOut;
      ebusPkg::diagBrx: selWord = mBrx;
      ebusPkg::diagArx: selWord = mArx;
      ebusPkg::diagAd:  selWord = adWord;
      default:          selWord = '0;
    endcase
    mEbusData = en ? selWord : '0;
    mEbusDrive = en;
    if (brLoad) begin
      mBr = mAr;
    end
    if (brxLoad) begin
      mBrx = mArx;
    end
    // Read sees the word from before this edge's write
    mFmOut = mFm[fmAddr];
    mFmOutKnown = mFmKnown[fmAddr];
    if (fmWrite == cramPkg::fmLeft || fmWrite == cramPkg::fmBoth) begin
      mFm[fmAddr][0:halfW-1] = mAr[0:halfW-1];
    end
    if (fmWrite == cramPkg::fmRight || fmWrite == cramPkg::fmBoth) begin
      mFm[fmAddr][halfW:`EDP_WIDTH-1] = mAr[halfW:`EDP_WIDTH-1];
    end
    if (fmWrite == cramPkg::fmBoth) begin
      mFmKnown[fmAddr] = 1'b1;
    end
    mAr = nAr;
    mArx = nArx;
    mMq = nMq;
  endtask

  // Check mid-cycle, then step the model over the edge
  task automatic runCycle();
    #1;
    checkOutputs();
    advanceModel();
    @(posedge eboxClk);
    #0.5;
  endtask

  task automatic waitDrive(input logic level, input int limit);
    int n;
    n = 0;
    while (ebusDrive !== level) begin
      if (n == limit) begin
        reportFail($sformatf("ebusDrive did not go to %0d within %0d cycles", level, limit));
      end
      runCycle();
      n++;
    end
  endtask

  task automatic idleInputs();
    adFunc = cramPkg::adAdd;
    adaSel = cramPkg::adaAr;
    adbSel = cramPkg::adbBr;
    arSel = cramPkg::arHold;
    arxSel = cramPkg::arxHold;
    mqSel = cramPkg::mqHold;
    fmWrite = cramPkg::fmNone;
    diagFunc = ebusPkg::diagIdle;
    brLoad = 1'b0;
    brxLoad = 1'b0;
    carryIn = 1'b0;
    adToEbus = 1'b0;
    magic = '0;
    fmAddr = '0;
    cacheData = '0;
    ebusIn = '0;
  endtask

  initial begin
    seed = 40429;
    rstN = 1'b0;
    idleInputs();
    mAr = '0;
    mArx = '0;
    mBr = '0;
    mBrx = '0;
    mMq = '0;
    mFmOut = '0;
    mEbusData = '0;
    mEbusDrive = 1'b0;
    mFmOutKnown = 1'b1;
    for (int i = 0; i < `FM_DEPTH; i++) begin
      mFm[i] = '0;
      mFmKnown[i] = 1'b0;
    end
    repeat (10) @(posedge eboxClk);
    #0.5;
    rstN = 1'b1;
    runCycle();

    // Fill every FM word while AR takes a new value each cycle
    for (int i = 0; i < `FM_DEPTH; i++) begin
      fmAddr = i[`FM_ADDR_W-1:0];
      arSel = cramPkg::arCache;
      fmWrite = cramPkg::fmBoth;
      cacheData = randWord();
      runCycle();
    end
    idleInputs();

    // Every AD function on random AR and BR
    arSel = cramPkg::arCache;
    cacheData = randWord();
    runCycle();
    brLoad = 1'b1;
    cacheData = randWord();
    runCycle();
    idleInputs();
    for (int k = 0; k < 8; k++) begin
      adFunc = cramPkg::adFuncE'(k[2:0]);
      carryIn = 1'b1;
      runCycle();
      carryIn = 1'b0;
      runCycle();
    end

    // Half clears, AR sources and the BR/BRX copies
    arSel = cramPkg::arClrLeft;
    runCycle();
    arSel = cramPkg::arCache;
    cacheData = randWord();
    runCycle();
    arSel = cramPkg::arClrRight;
    runCycle();
    arSel = cramPkg::arEbus;
    ebusIn = randWord();
    runCycle();
    adFunc = cramPkg::adXor;
    adbSel = cramPkg::adbMagic;
    magic = 9'h1a5;
    arSel = cramPkg::arAd;
    arxSel = cramPkg::arxCache;
    cacheData = randWord();
    runCycle();
    arSel = cramPkg::arArx;
    arxSel = cramPkg::arxHold;
    brLoad = 1'b1;
    brxLoad = 1'b1;
    runCycle();
    idleInputs();

    // MQ load and shifts with the sign set so shift right copies a one
    arSel = cramPkg::arCache;
    cacheData = randWord();
    cacheData[0] = 1'b1;
    runCycle();
    arSel = cramPkg::arHold;
    adFunc = cramPkg::adPassA;
    mqSel = cramPkg::mqLoadAd;
    runCycle();
    mqSel = cramPkg::mqShr;
    runCycle();
    runCycle();
    arSel = cramPkg::arCache;
    cacheData = '1;
    mqSel = cramPkg::mqHold;
    runCycle();
    // All ones plus one carries out of bit 0
    arSel = cramPkg::arHold;
    adFunc = cramPkg::adAdd;
    adbSel = cramPkg::adbMagic;
    magic = 9'd1;
    mqSel = cramPkg::mqShl;
    runCycle();
    adFunc = cramPkg::adAnd;
    runCycle();
    idleInputs();

    // Halfword FM writes merge into the stored word
    arSel = cramPkg::arCache;
    cacheData = randWord();
    fmAddr = 4'd5;
    runCycle();
    arSel = cramPkg::arHold;
    fmWrite = cramPkg::fmLeft;
    runCycle();
    arSel = cramPkg::arCache;
    cacheData = randWord();
    fmWrite = cramPkg::fmNone;
    runCycle();
    arSel = cramPkg::arHold;
    fmWrite = cramPkg::fmRight;
    runCycle();
    fmWrite = cramPkg::fmNone;
    adbSel = cramPkg::adbFm;
    adFunc = cramPkg::adPassB;
    runCycle();
    runCycle();
    idleInputs();

    // Diagnostic reads, the AD transfer override and release
    diagFunc = ebusPkg::diagAr;
    waitDrive(1'b1, 1);
    for (int k = 0; k < 7; k++) begin
      diagFunc = ebusPkg::diagFuncE'(k[2:0]);
      runCycle();
    end
    adToEbus = 1'b1;
    diagFunc = ebusPkg::diagMq;
    adFunc = cramPkg::adSub;
    runCycle();
    adToEbus = 1'b0;
    diagFunc = ebusPkg::diagIdle;
    waitDrive(1'b0, 1);

    // Random microwords over every field
    for (int n = 0; n < 64; n++) begin
      rnd = $random(seed);
      adFunc = cramPkg::adFuncE'(rnd[2:0]);
      adaSel = cramPkg::adaSelE'(rnd[4:3]);
      adbSel = cramPkg::adbSelE'(rnd[6:5]);
      arSel = cramPkg::arSelE'(rnd[9:7]);
      arxSel = cramPkg::arxSelE'(rnd[11:10]);
      mqSel = cramPkg::mqSelE'(rnd[13:12]);
      fmWrite = cramPkg::fmWriteE'(rnd[15:14]);
      brLoad = rnd[16];
      brxLoad = rnd[17];
      carryIn = rnd[18];
      adToEbus = rnd[19];
      diagFunc = ebusPkg::diagFuncE'(rnd[22:20]);
      fmAddr = rnd[26:23];
      cacheData = randWord();
      ebusIn = randWord();
      magic = cacheData[`EDP_WIDTH-`MAGIC_W:`EDP_WIDTH-1];
      runCycle();
    end
    idleInputs();
    runCycle();

    $display("=== PASS ===");
    $finish;
  end

endmodule
